//--- build.f
sdmac_pkg.sv
scsi_byte_lane.sv
dma_word_fifo.sv
dma_sequencer.sv
dma_ctrl_regs.sv
sdmac_datapath_top.sv
tb_sdmac_datapath.sv

//--- Makefile
# Verilator build and run for the SCSI DMA datapath testbench
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_sdmac_datapath
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Simulation passed

.PHONY: run build lint clean

# The run fails unless the pass line appears in the simulator output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- tb_sdmac_datapath.sv
/*
 * Table-driven testbench for the SCSI DMA datapath covering reset state, PIO
 * write and read, DMA in both directions and FIFO back-pressure
 */
`timescale 1ns/1ps

module tb_sdmac_datapath import sdmac_pkg::*; ();

    typedef enum int {op_reset, op_pio_wr, op_pio_rd, op_to_scsi, op_from_scsi, op_backpr} op_t;

    logic              LS2CPU;
    logic              rst_n;
    logic              cpu_wr;
    logic              cpu_rd;
    logic              mem_wr;
    logic              mem_rd;
    logic              scsi_dreq;
    logic [addr_w-1:0] cpu_addr;
    logic [31:0]       cpu_wdata;
    logic [31:0]       mem_wdata;
    logic [31:0]       cpu_rdata;
    logic [31:0]       mem_rdata;
    logic [7:0]        scsi_data_in;
    logic [7:0]        scsi_data_out;
    logic              fifo_full;
    logic              fifo_empty;
    logic              scsi_oe;
    logic              scsi_dack;
    logic              done;

    // Stimulus table with one row per test holding its argument, data and expected value
    string       t_name [8];
    op_t         t_kind [8];
    int          t_arg  [8];
    logic [31:0] t_data [8];
    logic [31:0] t_exp  [8];
    int          n_tests = 0;

    int          seed = 13;
    string       cur_name;
    int          test_errors;
    int          errors = 0;
    int          n_failed = 0;
    int          cycle_count = 0;
    int          cycle_limit = 100000;
    // Bytes that the SCSI side handed over during a from-SCSI transfer
    logic [7:0]  rx_q [$];

    sdmac_datapath_top UUT (.*);

    initial begin
        LS2CPU = 1'b0;
        forever #4 LS2CPU = ~LS2CPU;
    end

    // Watchdog on a cycle budget that scales with the DMA transfer lengths
    always @(posedge LS2CPU) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic mismatch(input string what, input logic [31:0] exp, input logic [31:0] act);
        $display("CHECK FAILED %s %s: expected %h actual %h", cur_name, what, exp, act);
        test_errors++;
    endtask

    task automatic failure(input string msg);
        $display("ERROR in %s: %s", cur_name, msg);
        test_errors++;
    endtask

    task automatic add_test(input string name, input op_t kind, input int arg,
                            input logic [31:0] data, input logic [31:0] exp);
        t_name[n_tests] = name;
        t_kind[n_tests] = kind;
        t_arg[n_tests]  = arg;
        t_data[n_tests] = data;
        t_exp[n_tests]  = exp;
        n_tests++;
    endtask

    // One-cycle CPU strobes that the DUT takes at the closing rising edge
    task automatic write_register(input logic [addr_w-1:0] addr, input logic [31:0] data);
        @(negedge LS2CPU);
        cpu_wr    = 1'b1;
        cpu_addr  = addr;
        cpu_wdata = data;
        @(negedge LS2CPU);
        cpu_wr = 1'b0;
    endtask

    task automatic read_register(input logic [addr_w-1:0] addr, output logic [31:0] data);
        @(negedge LS2CPU);
        cpu_rd   = 1'b1;
        cpu_addr = addr;
        #2;
        data = cpu_rdata;
        @(negedge LS2CPU);
        cpu_rd = 1'b0;
    endtask

    // Big-endian packing puts byte k of a word in bits 31-8k downward
    function automatic logic [31:0] pack_word(input int first, input int n);
        logic [31:0] w;
        w = '0;
        for (int k = 0; k < n; k++) begin
            w[31-8*k -: 8] = rx_q[first+k];
        end
        return w;
    endfunction

    // Done marks the end of a transfer whose latency depends on the gaps
    task automatic wait_for_done();
        while (done !== 1'b1) begin
            @(negedge LS2CPU);
        end
    endtask

    // Offer bytes under scsi_dreq and keep each one that gets an acknowledge
    task automatic feed_scsi_bytes(input int n, input bit gaps);
        int got;
        got = 0;
        while (got < n) begin
            @(negedge LS2CPU);
            scsi_dreq    = !gaps || (($random(seed) & 3) != 0);
            scsi_data_in = 8'($random(seed));
            #2;
            if (scsi_dack) begin
                rx_q.push_back(scsi_data_in);
                got++;
            end
        end
        @(negedge LS2CPU);
        scsi_dreq = 1'b0;
    endtask

    // Pop words back to back and compare each head with the packed byte stream
    task automatic drain_words(input int first, input int n, input int total);
        logic [31:0] exp;
        int          nb;
        for (int w = first; w < first + n; w++) begin
            nb  = (total - 4 * w < 4) ? total - 4 * w : 4;
            exp = pack_word(4 * w, nb);
            @(negedge LS2CPU);
            mem_rd = 1'b1;
            #2;
            if (fifo_empty) failure("FIFO empty while a packed word was expected");
            if (mem_rdata !== exp) mismatch($sformatf("word %0d", w), exp, mem_rdata);
        end
        @(negedge LS2CPU);
        mem_rd = 1'b0;
        #2;
        if (!fifo_empty) failure("FIFO still holds data after the last expected word");
    endtask

    task automatic reset_check(input logic [addr_w-1:0] addr, input logic [31:0] exp);
        logic [31:0] got;
        if (scsi_oe !== 1'b0 || scsi_dack !== 1'b0 || done !== 1'b0) begin
            failure("scsi_oe, scsi_dack or done is active after reset");
        end
        if (fifo_empty !== 1'b1) failure("fifo_empty is low after reset");
        read_register(addr, got);
        if (got !== exp) mismatch("status", exp, got);
    endtask

    // The byte is on the SCSI bus only in the strobe cycle
    task automatic pio_write(input logic [addr_w-1:0] addr, input logic [31:0] data,
                             input logic [31:0] exp);
        @(negedge LS2CPU);
        cpu_wr    = 1'b1;
        cpu_addr  = addr;
        cpu_wdata = data;
        #2;
        if (scsi_oe !== 1'b1) failure("scsi_oe low during the PIO write strobe");
        if ({24'h0, scsi_data_out} !== exp) mismatch("scsi_data_out", exp, {24'h0, scsi_data_out});
        @(negedge LS2CPU);
        cpu_wr = 1'b0;
        #2;
        if (scsi_oe !== 1'b0) failure("scsi_oe still high after the PIO write strobe");
    endtask

    // The bus changes in the read cycle so only the latched byte can match
    task automatic pio_read(input logic [addr_w-1:0] addr, input logic [7:0] b,
                            input logic [31:0] exp);
        logic [31:0] got;
        @(negedge LS2CPU);
        scsi_data_in = b;
        @(negedge LS2CPU);
        scsi_data_in = ~b;
        cpu_rd       = 1'b1;
        cpu_addr     = addr;
        #2;
        got = cpu_rdata;
        @(negedge LS2CPU);
        cpu_rd = 1'b0;
        if (got !== exp) mismatch("cpu_rdata", exp, got);
    endtask

    task automatic to_scsi_dma(input int n);
        logic [31:0] words [$];
        logic [7:0]  exp;
        int          got;
        for (int w = 0; w < (n + 3) / 4; w++) begin
            words.push_back($random(seed));
            @(negedge LS2CPU);
            if (fifo_full) failure("FIFO full before a memory push");
            mem_wr    = 1'b1;
            mem_wdata = words[w];
        end
        @(negedge LS2CPU);
        mem_wr = 1'b0;
        write_register(reg_control_addr, 32'h3);
        write_register(reg_count_addr, 32'(n));
        got = 0;
        while (got < n) begin
            @(negedge LS2CPU);
            scsi_dreq = ($random(seed) & 3) != 0;
            #2;
            if (scsi_dack) begin
                // Offset 0 of each word is bits 31:24
                exp = 8'(words[got / 4] >> (24 - 8 * (got % 4)));
                if (!scsi_oe) failure("scsi_oe low during a to-SCSI acknowledge");
                if (scsi_data_out !== exp) begin
                    mismatch($sformatf("byte %0d", got), {24'h0, exp}, {24'h0, scsi_data_out});
                end
                got++;
            end
        end
        @(negedge LS2CPU);
        scsi_dreq = 1'b0;
        wait_for_done();
        if (!fifo_empty) failure("FIFO not empty after the to-SCSI transfer");
    endtask

    task automatic from_scsi_dma(input int n);
        rx_q.delete();
        write_register(reg_control_addr, 32'h1);
        write_register(reg_count_addr, 32'(n));
        if (done !== 1'b0) failure("done still high after a new count load");
        feed_scsi_bytes(n, 1'b1);
        wait_for_done();
        drain_words(0, (n + 3) / 4, n);
    endtask

    task automatic back_pressure(input int n);
        rx_q.delete();
        write_register(reg_control_addr, 32'h1);
        write_register(reg_count_addr, 32'(n));
        if (done !== 1'b0) failure("done still high after a new count load");
        feed_scsi_bytes(fifo_depth * 4, 1'b0);
        // Eight packed words fill the FIFO and further requests must stall
        for (int c = 0; c < 4; c++) begin
            @(negedge LS2CPU);
            scsi_dreq = 1'b1;
            #2;
            if (!fifo_full) failure("fifo_full low after 32 bytes without pops");
            if (scsi_dack) failure("scsi_dack high while the FIFO is full");
        end
        @(negedge LS2CPU);
        scsi_dreq = 1'b0;
        drain_words(0, fifo_depth, n);
        feed_scsi_bytes(n - fifo_depth * 4, 1'b0);
        wait_for_done();
        drain_words(fifo_depth, (n + 3) / 4 - fifo_depth, n);
    endtask

    initial begin
        int          total_len;
        logic [31:0] r;
        logic [7:0]  b;
        rst_n        = 1'b0;
        cpu_wr       = 1'b0;
        cpu_rd       = 1'b0;
        cpu_addr     = '0;
        cpu_wdata    = '0;
        mem_wr       = 1'b0;
        mem_rd       = 1'b0;
        mem_wdata    = '0;
        scsi_data_in = '0;
        scsi_dreq    = 1'b0;

        // Status after reset has only the empty flag in bit 29
        add_test("reset_state", op_reset, int'(reg_count_addr), 32'h0, 32'h2000_0000);
        r = $random(seed);
        add_test("pio_write_lo", op_pio_wr, int'(reg_pio_lo_addr), r, {24'h0, r[7:0]});
        r = $random(seed);
        add_test("pio_write_hi", op_pio_wr, int'(reg_pio_hi_addr), r, {24'h0, r[23:16]});
        r = $random(seed);
        b = r[7:0];
        add_test("pio_read", op_pio_rd, int'(reg_pio_lo_addr), {24'h0, b}, {b, 8'h00, b, 8'h00});
        add_test("dma_to_scsi", op_to_scsi, 10, 32'h0, 32'h0);
        add_test("dma_from_scsi", op_from_scsi, 6, 32'h0, 32'h0);
        add_test("back_pressure", op_backpr, 36, 32'h0, 32'h0);

        total_len = 0;
        for (int i = 0; i < n_tests; i++) begin
            if (t_kind[i] inside {op_to_scsi, op_from_scsi, op_backpr}) total_len += t_arg[i];
        end
        cycle_limit = total_len * 4 + 200;

        repeat (4) @(negedge LS2CPU);
        rst_n = 1'b1;

        for (int i = 0; i < n_tests; i++) begin
            cur_name    = t_name[i];
            test_errors = 0;
            case (t_kind[i])
                op_reset:     reset_check(addr_w'(t_arg[i]), t_exp[i]);
                op_pio_wr:    pio_write(addr_w'(t_arg[i]), t_data[i], t_exp[i]);
                op_pio_rd:    pio_read(addr_w'(t_arg[i]), t_data[i][7:0], t_exp[i]);
                op_to_scsi:   to_scsi_dma(t_arg[i]);
                op_from_scsi: from_scsi_dma(t_arg[i]);
                default:      back_pressure(t_arg[i]);
            endcase
            if (test_errors == 0) begin
                $display("PASS  %s", cur_name);
            end else begin
                $display("FAIL  %s with %0d errors", cur_name, test_errors);
                n_failed++;
            end
            errors += test_errors;
        end

        $display("Tests run %0d, tests failed %0d, check errors %0d", n_tests, n_failed, errors);
        if (n_failed == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- sdmac_datapath_top.sv
/*
 * SCSI DMA datapath top: register block, byte lanes, word FIFO and sequencer
 */
`timescale 1ns/1ps

module sdmac_datapath_top import sdmac_pkg::*; (
    input  logic                LS2CPU,
    input  logic                rst_n,
    input  logic                cpu_wr,
    input  logic                cpu_rd,
    input  logic [addr_w-1:0]   cpu_addr,
    input  logic [word_w-1:0]   cpu_wdata,
    input  logic                mem_wr,
    input  logic [word_w-1:0]   mem_wdata,
    input  logic                mem_rd,
    input  logic [byte_w-1:0]   scsi_data_in,
    input  logic                scsi_dreq,
    output logic [word_w-1:0]   cpu_rdata,
    output logic [word_w-1:0]   mem_rdata,
    output logic                fifo_full,
    output logic                fifo_empty,
    output logic [byte_w-1:0]   scsi_data_out,
    output logic                scsi_oe,
    output logic                scsi_dack,
    output logic                done
);

    logic                dma_en;
    logic                to_scsi;
    logic                count_load;
    logic [count_w-1:0]  count_value;
    logic [count_w-1:0]  count_left;
    logic                cpu2s;
    logic                s2cpu;
    logic                a3;
    logic [word_w-1:0]   pio_rdata;
    logic                f2s;
    logic                s2f;
    logic [1:0]          byte_off;
    logic [byte_w-1:0]   rx_byte;
    logic                seq_push;
    logic [word_w-1:0]   seq_push_word;
    logic                seq_pop;
    logic [word_w-1:0]   head_word;

    // Memory reads and outgoing SCSI bytes both come from the FIFO head
    assign mem_rdata = head_word;

    dma_ctrl_regs u_regs (
        .LS2CPU(LS2CPU), .rst_n(rst_n),
        .cpu_wr(cpu_wr), .cpu_rd(cpu_rd), .cpu_addr(cpu_addr), .cpu_wdata(cpu_wdata),
        .pio_rdata(pio_rdata), .count_left(count_left), .done(done),
        .fifo_full(fifo_full), .fifo_empty(fifo_empty),
        .dma_en(dma_en), .to_scsi(to_scsi), .count_load(count_load),
        .count_value(count_value), .cpu2s(cpu2s), .s2cpu(s2cpu), .a3(a3),
        .cpu_rdata(cpu_rdata)
    );

    scsi_byte_lane u_lane (
        .LS2CPU(LS2CPU), .rst_n(rst_n),
        .cpu_wdata(cpu_wdata), .cpu2s(cpu2s), .a3(a3), .s2cpu(s2cpu),
        .f2s(f2s), .s2f(s2f), .byte_off(byte_off), .out_word(head_word),
        .scsi_data_in(scsi_data_in), .scsi_data_out(scsi_data_out),
        .scsi_oe(scsi_oe), .rx_byte(rx_byte), .pio_rdata(pio_rdata)
    );

    dma_word_fifo u_fifo (
        .LS2CPU(LS2CPU), .rst_n(rst_n),
        .mem_wr(mem_wr), .mem_wdata(mem_wdata), .mem_rd(mem_rd),
        .seq_push(seq_push), .seq_push_word(seq_push_word), .seq_pop(seq_pop),
        .head_word(head_word), .fifo_full(fifo_full), .fifo_empty(fifo_empty)
    );

    dma_sequencer u_seq (
        .LS2CPU(LS2CPU), .rst_n(rst_n),
        .dma_en(dma_en), .to_scsi(to_scsi), .count_load(count_load),
        .count_value(count_value), .scsi_dreq(scsi_dreq),
        .fifo_full(fifo_full), .fifo_empty(fifo_empty), .rx_byte(rx_byte),
        .scsi_dack(scsi_dack), .f2s(f2s), .s2f(s2f), .byte_off(byte_off),
        .seq_push(seq_push), .seq_push_word(seq_push_word), .seq_pop(seq_pop),
        .count_left(count_left), .done(done)
    );

endmodule

//--- dma_ctrl_regs.sv
/*
 * CPU register block: control register, count load, status readback
 * and decode of programmed SCSI byte accesses
 */
`timescale 1ns/1ps

module dma_ctrl_regs import sdmac_pkg::*; (
    input  logic                LS2CPU,
    input  logic                rst_n,
    input  logic                cpu_wr,
    input  logic                cpu_rd,
    input  logic [addr_w-1:0]   cpu_addr,
    input  logic [word_w-1:0]   cpu_wdata,
    input  logic [word_w-1:0]   pio_rdata,
    input  logic [count_w-1:0]  count_left,
    input  logic                done,
    input  logic                fifo_full,
    input  logic                fifo_empty,
    output logic                dma_en,
    output logic                to_scsi,
    output logic                count_load,
    output logic [count_w-1:0]  count_value,
    output logic                cpu2s,
    output logic                s2cpu,
    output logic                a3,
    output logic [word_w-1:0]   cpu_rdata
);

    logic [byte_w-1:0] ctrl_reg;
    logic              pio_hit;

    // Both PIO addresses reach the same SCSI byte, A3 picks the source lane
    assign pio_hit = (cpu_addr == reg_pio_lo_addr) || (cpu_addr == reg_pio_hi_addr);

    always_ff @(posedge LS2CPU or negedge rst_n) begin
        if (!rst_n) begin
            ctrl_reg <= '0;
        end else if (cpu_wr && (cpu_addr == reg_control_addr)) begin
            ctrl_reg <= cpu_wdata[byte_w-1:0];
        end
    end

    assign dma_en  = ctrl_reg[ctrl_dma_en_bit];
    assign to_scsi = ctrl_reg[ctrl_to_scsi_bit];

    // The sequencer loads the count at the edge closing the write strobe
    assign count_load  = cpu_wr && (cpu_addr == reg_count_addr);
    assign count_value = cpu_wdata[count_w-1:0];

    assign cpu2s = cpu_wr && pio_hit;
    assign s2cpu = cpu_rd && pio_hit;
    assign a3    = cpu_addr[3];

    // Read mux, unmapped addresses and idle cycles return zero
    always_comb begin
        cpu_rdata = '0;
        if (cpu_rd) begin
            case (cpu_addr)
                reg_control_addr: begin
                    cpu_rdata[byte_w-1:0] = ctrl_reg;
                end
                reg_count_addr: begin
                    cpu_rdata[stat_done_bit]  = done;
                    cpu_rdata[stat_full_bit]  = fifo_full;
                    cpu_rdata[stat_empty_bit] = fifo_empty;
                    cpu_rdata[count_w-1:0]    = count_left;
                end
                reg_pio_lo_addr, reg_pio_hi_addr: begin
                    cpu_rdata = pio_rdata;
                end
                default: begin
                    cpu_rdata = '0;
                end
            endcase
        end
    end

    a_rd_wr_exclusive: assert property (
        @(posedge LS2CPU) disable iff (!rst_n) !(cpu_wr && cpu_rd));

endmodule

//--- dma_sequencer.sv
/*
 * Byte-serial DMA engine with byte offset and count tracking, word packing
 * for the from-SCSI direction, FIFO strobes and the done flag
 */
`timescale 1ns/1ps

module dma_sequencer import sdmac_pkg::*; (
    input  logic                LS2CPU,
    input  logic                rst_n,
    input  logic                dma_en,
    input  logic                to_scsi,
    input  logic                count_load,
    input  logic [count_w-1:0]  count_value,
    input  logic                scsi_dreq,
    input  logic                fifo_full,
    input  logic                fifo_empty,
    input  logic [byte_w-1:0]   rx_byte,
    output logic                scsi_dack,
    output logic                f2s,
    output logic                s2f,
    output logic [1:0]          byte_off,
    output logic                seq_push,
    output logic [word_w-1:0]   seq_push_word,
    output logic                seq_pop,
    output logic [count_w-1:0]  count_left,
    output logic                done
);

    logic              xfer;
    logic              last_byte;
    logic              armed;
    logic [word_w-1:0] asm_word;
    logic [word_w-1:0] packed_word;

    // A byte moves only when the chip asks and the FIFO side can take part
    assign xfer = dma_en && (count_left != '0) && scsi_dreq
               && (to_scsi ? !fifo_empty : !fifo_full);

    assign scsi_dack = xfer;
    assign f2s       = xfer && to_scsi;
    assign s2f       = xfer && !to_scsi;

    // A word closes on its fourth byte or on the final byte of the count
    assign last_byte = (byte_off == 2'd3) || (count_left == count_w'(1));
    assign seq_pop   = f2s && last_byte;
    assign seq_push  = s2f && last_byte;

    // Merge the incoming byte into the lane picked by the offset
    always_comb begin
        packed_word = asm_word;
        case (byte_off)
            2'd0:    packed_word[31:24] = rx_byte;
            2'd1:    packed_word[23:16] = rx_byte;
            2'd2:    packed_word[15:8]  = rx_byte;
            default: packed_word[7:0]   = rx_byte;
        endcase
    end

    // The pushed word includes the byte of this cycle
    assign seq_push_word = packed_word;

    // Cleared after each push so a short final word has zero padding
    always_ff @(posedge LS2CPU) begin
        if (count_load || seq_push) begin
            asm_word <= '0;
        end else if (s2f) begin
            asm_word <= packed_word;
        end
    end

    always_ff @(posedge LS2CPU or negedge rst_n) begin
        if (!rst_n) begin
            byte_off   <= 2'd0;
            count_left <= '0;
            armed      <= 1'b0;
            done       <= 1'b0;
        end else if (count_load) begin
            byte_off   <= 2'd0;
            count_left <= count_value;
            armed      <= 1'b1;
            done       <= 1'b0;
        end else begin
            if (xfer) begin
                byte_off   <= byte_off + 2'd1;
                count_left <= count_left - 1'b1;
            end
            // Done follows one cycle after the count has run out
            if (armed && (count_left == '0)) begin
                done  <= 1'b1;
                armed <= 1'b0;
            end
        end
    end

    // Done is only shown once the count has run out
    a_done_at_zero: assert property (
        @(posedge LS2CPU) disable iff (!rst_n) done |-> (count_left == '0));

endmodule

//--- dma_word_fifo.sv
/*
 * Show-ahead word FIFO between the memory side and the DMA sequencer
 */
`timescale 1ns/1ps

module dma_word_fifo import sdmac_pkg::*; (
    input  logic                LS2CPU,
    input  logic                rst_n,
    input  logic                mem_wr,
    input  logic [word_w-1:0]   mem_wdata,
    input  logic                mem_rd,
    input  logic                seq_push,
    input  logic [word_w-1:0]   seq_push_word,
    input  logic                seq_pop,
    output logic [word_w-1:0]   head_word,
    output logic                fifo_full,
    output logic                fifo_empty
);

    logic [word_w-1:0]     mem [fifo_depth];
    logic [fifo_ptr_w-1:0] wr_ptr;
    logic [fifo_ptr_w-1:0] rd_ptr;
    logic [fifo_ptr_w:0]   level;
    logic                  push;
    logic                  pop;
    logic [word_w-1:0]     push_word;

    // Memory fills in the to-SCSI direction, the sequencer in the other one
    assign push      = mem_wr | seq_push;
    assign pop       = mem_rd | seq_pop;
    assign push_word = ({word_w{mem_wr}} & mem_wdata)
                     | ({word_w{seq_push}} & seq_push_word);

    always_ff @(posedge LS2CPU) begin
        if (push) begin
            mem[wr_ptr] <= push_word;
        end
    end

    // Pointers wrap naturally since the depth is a power of two
    always_ff @(posedge LS2CPU or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;
            endcase
        end
    end

    // Head word is visible without a pop strobe
    assign head_word  = mem[rd_ptr];
    assign fifo_full  = (level == (fifo_ptr_w + 1)'(fifo_depth));
    assign fifo_empty = (level == '0);

    a_no_overflow: assert property (
        @(posedge LS2CPU) disable iff (!rst_n) push |-> !fifo_full);

    a_no_underflow: assert property (
        @(posedge LS2CPU) disable iff (!rst_n) pop |-> !fifo_empty);

    // Only one side may fill the FIFO in a given direction
    a_one_source: assert property (
        @(posedge LS2CPU) disable iff (!rst_n) !(mem_wr && seq_push));

endmodule

//--- scsi_byte_lane.sv
/*
 * SCSI byte-lane steering with the big-endian byte-offset decoder
 * and the LS2CPU byte latch for programmed reads
 */
`timescale 1ns/1ps

module scsi_byte_lane import sdmac_pkg::*; (
    input  logic                LS2CPU,
    input  logic                rst_n,
    input  logic [word_w-1:0]   cpu_wdata,
    input  logic                cpu2s,
    input  logic                a3,
    input  logic                s2cpu,
    input  logic                f2s,
    input  logic                s2f,
    input  logic [1:0]          byte_off,
    input  logic [word_w-1:0]   out_word,
    input  logic [byte_w-1:0]   scsi_data_in,
    output logic [byte_w-1:0]   scsi_data_out,
    output logic                scsi_oe,
    output logic [byte_w-1:0]   rx_byte,
    output logic [word_w-1:0]   pio_rdata
);

    logic [3:0]        lane_sel;
    logic [byte_w-1:0] dma_byte;
    logic [byte_w-1:0] pio_byte;
    logic [byte_w-1:0] scsi_latch;

    // One-hot lane select, bit 3 is the upper byte 31:24 at offset 0
    always_comb begin
        lane_sel = 4'b0000;
        if (f2s) begin
            case (byte_off)
                2'd0:    lane_sel = 4'b1000;
                2'd1:    lane_sel = 4'b0100;
                2'd2:    lane_sel = 4'b0010;
                default: lane_sel = 4'b0001;
            endcase
        end
    end

    // Outgoing DMA byte, unselected lanes contribute zero
    assign dma_byte = ({byte_w{lane_sel[3]}} & out_word[31:24])
                    | ({byte_w{lane_sel[2]}} & out_word[23:16])
                    | ({byte_w{lane_sel[1]}} & out_word[15:8])
                    | ({byte_w{lane_sel[0]}} & out_word[7:0]);

    // A PIO write takes bits 23:16 when A3 is high and bits 7:0 otherwise
    assign pio_byte = cpu2s ? (a3 ? cpu_wdata[23:16] : cpu_wdata[7:0]) : '0;

    assign scsi_oe       = f2s | cpu2s;
    assign scsi_data_out = dma_byte | pio_byte;

    // The bus is sampled on every edge unless we are driving it ourselves
    always_ff @(posedge LS2CPU) begin
        if (!scsi_oe) begin
            scsi_latch <= scsi_data_in;
        end
    end

    // DMA packing takes the live byte, not the latched one
    assign rx_byte = s2f ? scsi_data_in : '0;

    // PIO reads show the latched byte on the two odd-numbered byte lanes
    assign pio_rdata = s2cpu ? {scsi_latch, 8'h00, scsi_latch, 8'h00} : '0;

    // The sequencer and the register block must never drive the bus at once
    a_single_driver: assert property (
        @(posedge LS2CPU) disable iff (!rst_n) !(f2s && cpu2s));

endmodule

//--- sdmac_pkg.sv
/*
 * Shared constants for the SCSI DMA datapath: CPU register addresses,
 * control and status bit positions, FIFO depth and datapath widths
 */
package sdmac_pkg;

    // Basic bus widths, a 32-bit CPU/memory word and an 8-bit SCSI byte
    localparam int byte_w = 8;
    localparam int word_w = 32;

    // CPU byte address width, bit 3 of an address is A3
    localparam int addr_w = 5;

    // Register map as seen from the CPU
    localparam logic [addr_w-1:0] reg_control_addr = 5'h00;
    localparam logic [addr_w-1:0] reg_count_addr   = 5'h04;
    localparam logic [addr_w-1:0] reg_pio_lo_addr  = 5'h10;
    localparam logic [addr_w-1:0] reg_pio_hi_addr  = 5'h18;

    // Control register bits
    localparam int ctrl_dma_en_bit  = 0;
    localparam int ctrl_to_scsi_bit = 1;

    // Status word layout, the remaining count sits in the low bits
    localparam int stat_done_bit  = 31;
    localparam int stat_full_bit  = 30;
    localparam int stat_empty_bit = 29;

    // Word FIFO between memory and the SCSI byte stream
    localparam int fifo_depth = 8;
    localparam int fifo_ptr_w = 3;

    // Byte counter of a DMA transfer
    localparam int count_w = 16;

endpackage
